//--- Makefile
# Verilator build and run for the SPI frame master testbench.

VERILATOR ?= verilator
TOP       ?= tb_spi_frame_master
RTL_TOP   ?= spi_frame_master
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -j 0
LINTFLAGS ?= -Wall

PASS_TEXT := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation prints the pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- source/frame_hoarder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_hoarder #(
  parameter int DATA_WIDTH = frame_pkg::FRAME_WIDTH_DEFAULT
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     req,
  input  wire [DATA_WIDTH-1:0]    tx_word,
  input  wire                     byte_ack,
  input  wire spi_pkg::spi_byte_t byte_rx,
  output logic                    ack,
  output logic [DATA_WIDTH-1:0]   rx_word,
  output logic                    cs_n,
  output logic                    byte_req,
  output spi_pkg::spi_byte_t      byte_tx
);

  import frame_pkg::*;

  localparam int BW     = $bits(byte_tx);
  localparam int NBYTES = DATA_WIDTH / BW;
  localparam int CNT_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(NBYTES - 1);

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [CNT_W-1:0]      byte_cnt_t;

  hoarder_state_e state;
  byte_cnt_t      byte_cnt;
  word_t          frame_q;
  word_t          rx_q;
  word_t          tx_shift;
  logic           last_byte;
  logic           issue;
  logic           capture;

  // Byte zero is the least significant byte of the frame.
  assign tx_shift  = frame_q >> (BW * int'(byte_cnt));
  assign last_byte = (byte_cnt == LAST_BYTE);
  assign issue     = (state == BYTE_REQ) && !byte_ack;
  assign capture   = (state == BYTE_WAIT) && byte_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      byte_cnt <= '0;
      ack      <= 1'b0;
      cs_n     <= 1'b1;
      byte_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            cs_n  <= 1'b0;
            state <= LOAD;
          end
        end

        LOAD: begin
          byte_cnt <= '0;
          state    <= BYTE_REQ;
        end

        BYTE_REQ: begin
          // The engine must have dropped its previous ack first.
          if (!byte_ack) begin
            byte_req <= 1'b1;
            state    <= BYTE_WAIT;
          end
        end

        BYTE_WAIT: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            if (last_byte) begin
              byte_cnt <= '0;
              cs_n     <= 1'b1;
              state    <= FRAME_ACK;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              state    <= BYTE_REQ;
            end
          end
        end

        FRAME_ACK: begin
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0; // Host has released req.
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOAD) begin
      frame_q <= tx_word;
    end
    if (issue) begin
      byte_tx <= tx_shift[BW-1:0];
    end
    // Every byte of the frame passes through, so the first one ends on top.
    if (capture) begin
      rx_q <= (rx_q << BW) | DATA_WIDTH'(byte_rx);
    end
    if ((state == FRAME_ACK) && !ack) begin
      rx_word <= rx_q;
    end
  end

endmodule

`default_nettype wire

//--- source/frame_pkg.sv
`default_nettype none

package frame_pkg;

  // Word width used when the top level is not overridden.
  localparam int FRAME_WIDTH_DEFAULT = 32;

  // Frame sequencing from the host request to the host ack.
  typedef enum logic [2:0] {
    IDLE,      // Chip select high and waiting for req.
    LOAD,      // Capture the transmit word.
    BYTE_REQ,  // Present the next byte to the engine.
    BYTE_WAIT, // Wait for the engine to return the received byte.
    FRAME_ACK  // Hold ack and rx_word until req falls.
  } hoarder_state_e;

endpackage

`default_nettype wire

//--- source/spi_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine #(
  parameter int CLK_DIV = 2
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     byte_req,
  input  wire spi_pkg::spi_byte_t byte_tx,
  input  wire                     miso,
  output logic                    byte_ack,
  output spi_pkg::spi_byte_t      byte_rx,
  output logic                    sclk,
  output logic                    mosi
);

  import spi_pkg::*;

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int BIT_W = $clog2(SPI_BYTE_WIDTH);
  localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(CLK_DIV - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(SPI_BYTE_WIDTH - 1);

  typedef logic [DIV_W-1:0] div_cnt_t;
  typedef logic [BIT_W-1:0] bit_cnt_t;

  spi_state_e state;
  div_cnt_t   div_cnt;
  bit_cnt_t   bit_cnt;
  spi_byte_t  shift_q;
  logic       half_done;
  logic       start;
  logic       sclk_rise;

  assign half_done = (div_cnt == LAST_DIV);
  assign start     = (state == IDLE) && byte_req;
  assign sclk_rise = (state == SHIFT_LOW) && half_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      byte_ack <= 1'b0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (byte_req) begin
            mosi    <= byte_tx[SPI_BYTE_WIDTH-1]; // First bit is set up a half-period early.
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= SHIFT_LOW;
          end
        end

        SHIFT_LOW: begin
          if (half_done) begin
            div_cnt <= '0;
            sclk    <= 1'b1;
            state   <= SHIFT_HIGH;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        SHIFT_HIGH: begin
          if (half_done) begin
            div_cnt <= '0;
            sclk    <= 1'b0;
            if (bit_cnt == LAST_BIT) begin
              mosi  <= 1'b0; // Line returns low between bytes.
              state <= DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= shift_q[SPI_BYTE_WIDTH-1]; // Next bit on the falling edge.
              state   <= SHIFT_LOW;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        DONE: begin
          if (!byte_ack) begin
            byte_ack <= 1'b1;
          end else if (!byte_req) begin
            byte_ack <= 1'b0; // Return to zero completes the byte.
            state    <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // One register serves both directions. Transmit bits leave at the top
  // while miso bits enter at the bottom.
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= byte_tx;
    end else if (sclk_rise) begin
      shift_q <= {shift_q[SPI_BYTE_WIDTH-2:0], miso};
    end
    if ((state == DONE) && !byte_ack) begin
      byte_rx <= shift_q;
    end
  end

endmodule

`default_nettype wire

//--- source/spi_frame_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_master #(
  parameter int DATA_WIDTH = frame_pkg::FRAME_WIDTH_DEFAULT,
  parameter int CLK_DIV    = 2
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  req,
  input  wire [DATA_WIDTH-1:0] tx_word,
  input  wire                  miso,
  output wire                  ack,
  output wire [DATA_WIDTH-1:0] rx_word,
  output wire                  cs_n,
  output wire                  sclk,
  output wire                  mosi
);

  import spi_pkg::*;

  logic      byte_req;
  logic      byte_ack;
  spi_byte_t byte_tx;
  spi_byte_t byte_rx;

  frame_hoarder #(
    .DATA_WIDTH (DATA_WIDTH)
  ) hoarder0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .tx_word  (tx_word),
    .byte_ack (byte_ack),
    .byte_rx  (byte_rx),
    .ack      (ack),
    .rx_word  (rx_word),
    .cs_n     (cs_n),
    .byte_req (byte_req),
    .byte_tx  (byte_tx)
  );

  spi_byte_engine #(
    .CLK_DIV (CLK_DIV)
  ) engine0 (
    .clk      (clk),
    .rst      (rst),
    .byte_req (byte_req),
    .byte_tx  (byte_tx),
    .miso     (miso),
    .byte_ack (byte_ack),
    .byte_rx  (byte_rx),
    .sclk     (sclk),
    .mosi     (mosi)
  );

endmodule

`default_nettype wire

//--- source/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Bits moved on the bus in one chip-select-independent transfer.
  localparam int SPI_BYTE_WIDTH = 8;

  typedef logic [SPI_BYTE_WIDTH-1:0] spi_byte_t;

  // The engine leaves IDLE on a byte request and returns after the ack handshake.
  typedef enum logic [1:0] {
    IDLE,       // Waiting for byte_req.
    SHIFT_LOW,  // sclk low for one half-period.
    SHIFT_HIGH, // sclk high for one half-period.
    DONE        // Byte is complete and byte_ack is offered.
  } spi_state_e;

endpackage

`default_nettype wire

//--- sources.f
source/spi_pkg.sv
source/frame_pkg.sv
source/spi_byte_engine.sv
source/frame_hoarder.sv
source/spi_frame_master.sv
tb/spi_slave_model.sv
tb/tb_spi_frame_master.sv

//--- tb/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model #(
  parameter logic [31:0] SEED = 32'd1
) (
  input  wire cs_n,
  input  wire sclk,
  input  wire mosi,
  output wire miso
);

  import spi_pkg::*;

  // Bytes of every frame in bus order, read by the testbench.
  spi_byte_t mosi_bytes[$];
  spi_byte_t miso_bytes[$];

  logic [31:0] rand_q    = SEED;
  spi_byte_t   tx_byte   = '0;
  spi_byte_t   rx_byte   = '0;
  int          bit_cnt   = 0;
  logic        miso_q    = 1'b0;
  logic        cs_prev   = 1'b1;
  logic        sclk_prev = 1'b0;

  assign miso = miso_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Mode 0 slave. Bits change while sclk is low and mosi is taken on the rising edge.
  always @(cs_n or sclk) begin
    if (cs_n === 1'b0 && cs_prev !== 1'b0) begin
      rand_q  = xorshift32(rand_q);
      tx_byte = rand_q[SPI_BYTE_WIDTH-1:0];
      bit_cnt = 0;
      miso_q  = tx_byte[SPI_BYTE_WIDTH-1]; // First bit ready before the first edge.
    end else if (cs_n === 1'b0 && sclk === 1'b1 && sclk_prev === 1'b0) begin
      rx_byte = {rx_byte[SPI_BYTE_WIDTH-2:0], mosi};
      bit_cnt++;
      if (bit_cnt == SPI_BYTE_WIDTH) begin
        mosi_bytes.push_back(rx_byte);
        miso_bytes.push_back(tx_byte);
        rand_q  = xorshift32(rand_q);
        tx_byte = rand_q[SPI_BYTE_WIDTH-1:0];
        bit_cnt = 0;
      end
    end else if (cs_n === 1'b0 && sclk === 1'b0 && sclk_prev === 1'b1) begin
      miso_q = tx_byte[SPI_BYTE_WIDTH-1-bit_cnt];
    end
    cs_prev   = cs_n;
    sclk_prev = sclk;
  end

endmodule

`default_nettype wire

//--- tb/tb_spi_frame_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_frame_master;

  import frame_pkg::*;
  import spi_pkg::*;

  localparam int DATA_WIDTH = FRAME_WIDTH_DEFAULT;
  localparam int CLK_DIV    = 2;
  localparam int NBYTES     = DATA_WIDTH / SPI_BYTE_WIDTH;
  localparam int NUM_FRAMES = 200;
  localparam int FRAME_TIMEOUT = 40 * NBYTES * (CLK_DIV + 1) + 100; // Well above one frame.
  localparam int CHECK_W    = (DATA_WIDTH > 32) ? DATA_WIDTH : 32;
  localparam logic [31:0] SEED = 32'd11616;

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic [DATA_WIDTH-1:0] tx_word;
  wire                   ack;
  wire  [DATA_WIDTH-1:0] rx_word;
  wire                   cs_n;
  wire                   sclk;
  wire                   mosi;
  wire                   miso;

  logic [31:0] rand_state;
  logic        sclk_prev;
  int          total_rises;
  int          check_count;
  int          mismatch_count;
  int          timeout_count;
  int          frame_idx;
  int          idle_idx;

  spi_frame_master #(
    .DATA_WIDTH (DATA_WIDTH),
    .CLK_DIV    (CLK_DIV)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .tx_word (tx_word),
    .miso    (miso),
    .ack     (ack),
    .rx_word (rx_word),
    .cs_n    (cs_n),
    .sclk    (sclk),
    .mosi    (mosi)
  );

  spi_slave_model #(
    .SEED (SEED + 32'd1)
  ) slave0 (
    .cs_n (cs_n),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input logic [CHECK_W-1:0] actual, input logic [CHECK_W-1:0] expected,
                       input string msg);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t ns: %s (got 0x%0h, expected 0x%0h)",
               $time, msg, actual, expected);
    end
  endtask

  // Every cycle passes through here, so framing is watched continuously.
  task automatic tick();
    @(negedge clk);
    if (sclk === 1'b1 && sclk_prev === 1'b0) begin
      total_rises++;
      check(cs_n, 1'b0, "sclk rose while cs_n was high");
    end
    sclk_prev = sclk;
    if (ack === 1'b1) begin
      check(cs_n, 1'b1, "cs_n low while ack is high");
    end
  endtask

  task automatic wait_for_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level && n < FRAME_TIMEOUT) begin
      tick();
      n++;
    end
    if (ack !== level) begin
      timeout_count++;
      $display("Timeout at %0t ns: ack never went to %0b %s.", $time, level, what);
    end
  endtask

  task automatic run_frame(input int idx);
    logic [DATA_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] expected_rx;
    logic [DATA_WIDTH-1:0] held_rx;
    int gap;
    int hold;
    int rises_start;
    int rises_at_ack;
    int base;
    int i;

    rand_state = xorshift32(rand_state);
    gap = int'(rand_state % 6);
    repeat (gap) tick();

    word = '0;
    for (i = 0; i < NBYTES; i++) begin
      rand_state = xorshift32(rand_state);
      word = (word << SPI_BYTE_WIDTH) | DATA_WIDTH'(rand_state[7:0]);
    end

    rises_start = total_rises;
    base        = idx * NBYTES;
    tx_word     = word;
    req         = 1'b1;
    wait_for_ack(1'b1, "after req rose");
    if (timeout_count != 0) begin
      return;
    end

    rises_at_ack = total_rises;
    check(rises_at_ack - rises_start, SPI_BYTE_WIDTH * NBYTES,
          $sformatf("frame %0d sclk rising edges", idx));
    check(slave0.mosi_bytes.size(), base + NBYTES, $sformatf("frame %0d slave bytes", idx));
    if (slave0.mosi_bytes.size() >= base + NBYTES) begin
      expected_rx = '0;
      for (i = 0; i < NBYTES; i++) begin
        // Byte i of the word goes out i-th, so the LSB byte leads.
        check(slave0.mosi_bytes[base + i], word[SPI_BYTE_WIDTH*i +: SPI_BYTE_WIDTH],
              $sformatf("frame %0d mosi byte %0d", idx, i));
        expected_rx = (expected_rx << SPI_BYTE_WIDTH) |
                      DATA_WIDTH'(slave0.miso_bytes[base + i]);
      end
      check(rx_word, expected_rx, $sformatf("frame %0d rx_word", idx));
    end

    held_rx = rx_word;
    rand_state = xorshift32(rand_state);
    hold = int'(rand_state % 5);
    for (i = 0; i < hold; i++) begin
      tick();
      check(ack, 1'b1, $sformatf("frame %0d ack under back-pressure", idx));
      check(rx_word, held_rx, $sformatf("frame %0d rx_word under back-pressure", idx));
    end
    check(total_rises, rises_at_ack, $sformatf("frame %0d sclk edge after ack", idx));
    req = 1'b0;
    wait_for_ack(1'b0, "after req fell");
  endtask

  initial begin
    rand_state     = SEED;
    rst            = 1'b1;
    req            = 1'b0;
    tx_word        = '0;
    sclk_prev      = 1'b0;
    total_rises    = 0;
    check_count    = 0;
    mismatch_count = 0;
    timeout_count  = 0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    sclk_prev = sclk;

    for (idle_idx = 0; idle_idx < 4; idle_idx++) begin
      tick();
      check(ack, 1'b0, "ack after reset");
      check(cs_n, 1'b1, "cs_n after reset");
      check(sclk, 1'b0, "sclk after reset");
      check(mosi, 1'b0, "mosi after reset");
    end
    check(slave0.mosi_bytes.size(), 0, "slave bytes before the first frame");

    for (frame_idx = 0; frame_idx < NUM_FRAMES && timeout_count == 0; frame_idx++) begin
      run_frame(frame_idx);
    end

    $display("Frames: %0d, checks: %0d, mismatches: %0d, timeouts: %0d",
             frame_idx, check_count, mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
